// ==== Makefile ====
TOP := tb_mod2011

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f include/mod_params.svh $(wildcard rtl/*.sv) test/tb_mod2011.sv
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o V$(TOP)

# The simulator output goes to sim.log and the verdict comes from that log
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST OK" sim.log

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== include/mod_params.svh ====
`ifndef MOD_PARAMS_SVH
`define MOD_PARAMS_SVH

// Modulus and the residue of 2^11 with respect to it
`define MOD_MODULUS 2011
`define MOD_FOLD 37

`define RESIDUE_BITS 11
`define CHUNK_BITS 6

`define WB_DATA_BITS 32
`define WB_ADR_BITS 3

// Operand is six bus words split into two 96 bit halves
`define OPERAND_WORDS 6
`define HALF_BITS 96
`define HALF_CHUNKS 16

`define ADR_CTRL 3'd6
`define ADR_STATUS 3'd7

`endif

// ==== rtl/chunk_residue_lane.sv ====
`timescale 1ns/1ps
`include "mod_params.svh"

module chunk_residue_lane (
	input logic  clk,
	input logic  rst,
	lane_if.lane lif
);
	import mod_pkg::*;

	typedef logic [$clog2(`HALF_CHUNKS)-1:0] count_t;

	lane_state_t state;
	half_operand_t shift_q;
	residue_t acc;
	count_t count;
	logic done;
	chunk_t chunk;

	// Chunks are taken most significant first
	assign chunk = shift_q[`HALF_BITS-1 -: `CHUNK_BITS];

	assign lif.residue = acc;
	assign lif.done = done;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= LANE_IDLE;
			count <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				LANE_IDLE:
				begin
					if (lif.start)
					begin
						state <= LANE_RUN;
						count <= '0;
					end
				end
				LANE_RUN:
				begin
					count <= count + 1'b1;
					if (count == count_t'(`HALF_CHUNKS - 1))
					begin
						state <= LANE_IDLE;
						done <= 1'b1;
					end
				end
				default:
					state <= LANE_IDLE;
			endcase
		end
	end

	// Horner step: acc*64 + chunk is exactly the concatenation of the two
	always_ff @(posedge clk)
	begin
		if (state == LANE_IDLE && lif.start)
		begin
			shift_q <= lif.operand;
			acc <= '0;
		end
		else if (state == LANE_RUN)
		begin
			shift_q <= shift_q << `CHUNK_BITS;
			acc <= fold_reduce({acc, chunk});
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		lif.done |-> lif.residue < residue_t'(`MOD_MODULUS))
		else $error("lane residue out of range at done");

endmodule

// ==== rtl/lane_if.sv ====
`timescale 1ns/1ps

// One instance per lane, shared by the register block, the lane and the combiner
interface lane_if;

	logic start;
	mod_pkg::half_operand_t operand;
	mod_pkg::residue_t residue;
	logic done;

	modport regs (
		output start,
		output operand
	);

	modport lane (
		input  start,
		input  operand,
		output residue,
		output done
	);

	modport comb (
		input residue,
		input done
	);

endinterface

// ==== rtl/mod2011_top.sv ====
`timescale 1ns/1ps

module mod2011_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              cyc,
	input  logic              stb,
	input  logic              we,
	input  mod_pkg::wb_adr_t  adr,
	input  mod_pkg::wb_data_t dat_w,
	output mod_pkg::wb_data_t dat_r,
	output logic              ack
);
	import mod_pkg::*;

	residue_t result;
	logic result_strobe;

	// Low lane takes words 0 to 2 and the high lane words 3 to 5
	lane_if lane_lo ();
	lane_if lane_hi ();

	wb_mod_regs regs_u (
		.clk           (clk),
		.rst           (rst),
		.cyc           (cyc),
		.stb           (stb),
		.we            (we),
		.adr           (adr),
		.dat_w         (dat_w),
		.dat_r         (dat_r),
		.ack           (ack),
		.lane_lo       (lane_lo),
		.lane_hi       (lane_hi),
		.result        (result),
		.result_strobe (result_strobe)
	);

	chunk_residue_lane lane_lo_u (
		.clk (clk),
		.rst (rst),
		.lif (lane_lo)
	);

	chunk_residue_lane lane_hi_u (
		.clk (clk),
		.rst (rst),
		.lif (lane_hi)
	);

	residue_combiner combiner_u (
		.clk           (clk),
		.rst           (rst),
		.lo            (lane_lo),
		.hi            (lane_hi),
		.result        (result),
		.result_strobe (result_strobe)
	);

endmodule

// ==== rtl/mod_pkg.sv ====
`include "mod_params.svh"

package mod_pkg;

	typedef logic [`RESIDUE_BITS-1:0] residue_t;
	typedef logic [`CHUNK_BITS-1:0] chunk_t;
	typedef logic [`RESIDUE_BITS+`CHUNK_BITS-1:0] wide_sum_t;
	typedef logic [`WB_DATA_BITS-1:0] wb_data_t;
	typedef logic [`WB_ADR_BITS-1:0] wb_adr_t;
	typedef logic [`HALF_BITS-1:0] half_operand_t;

	typedef enum logic {
		LANE_IDLE,
		LANE_RUN
	} lane_state_t;

	// Bits above 2^11 are worth 37 each, so they are folded back into the low part
	// Four passes bring any 17 bit value below 2048
	function automatic residue_t fold_reduce(input wide_sum_t value);
		wide_sum_t v;
		v = value;
		for (int i = 0; i < 4; i++)
		begin
			if (v[`RESIDUE_BITS+`CHUNK_BITS-1:`RESIDUE_BITS] != '0)
				v = wide_sum_t'(v[`RESIDUE_BITS-1:0])
					+ wide_sum_t'(v[`RESIDUE_BITS+`CHUNK_BITS-1:`RESIDUE_BITS])
					* wide_sum_t'(`MOD_FOLD);
		end
		if (v >= wide_sum_t'(`MOD_MODULUS))
			v = v - wide_sum_t'(`MOD_MODULUS);
		return residue_t'(v);
	endfunction

	// Weight of the high half, 2^96 mod 2011
	function automatic residue_t half_weight();
		int w;
		w = 1;
		for (int i = 0; i < `HALF_BITS; i++)
			w = (w * 2) % `MOD_MODULUS;
		return residue_t'(w);
	endfunction

endpackage

// ==== rtl/residue_combiner.sv ====
`timescale 1ns/1ps
`include "mod_params.svh"

module residue_combiner (
	input  logic              clk,
	input  logic              rst,
	lane_if.comb              lo,
	lane_if.comb              hi,
	output mod_pkg::residue_t result,
	output logic              result_strobe
);
	import mod_pkg::*;

	localparam residue_t HALF_W = half_weight();

	// The weight is applied as two partial products so every sum fits wide_sum_t
	localparam wide_sum_t W_HI = wide_sum_t'(HALF_W[`RESIDUE_BITS-1:`CHUNK_BITS]);
	localparam wide_sum_t W_LO = wide_sum_t'(HALF_W[`CHUNK_BITS-1:0]);

	residue_t part_hi;
	residue_t part_sh;
	residue_t weighted;
	residue_t merged;
	logic both_done;

	assign both_done = lo.done && hi.done;

	always_comb
	begin
		part_hi = fold_reduce(wide_sum_t'(hi.residue) * W_HI);
		part_sh = fold_reduce({part_hi, chunk_t'(0)});
		weighted = fold_reduce(wide_sum_t'(part_sh) + wide_sum_t'(hi.residue) * W_LO);
		merged = fold_reduce(wide_sum_t'(weighted) + wide_sum_t'(lo.residue));
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			result_strobe <= 1'b0;
		else
			result_strobe <= both_done;
	end

	always_ff @(posedge clk)
	begin
		if (both_done)
			result <= merged;
	end

	// Both lanes see the same start and run a fixed number of chunks
	assert property (@(posedge clk) disable iff (rst) lo.done == hi.done)
		else $error("lane done pulses do not coincide");

	assert property (@(posedge clk) disable iff (rst)
		result_strobe |-> result < residue_t'(`MOD_MODULUS))
		else $error("combined residue out of range");

endmodule

// ==== rtl/wb_mod_regs.sv ====
`timescale 1ns/1ps
`include "mod_params.svh"

module wb_mod_regs (
	input  logic              clk,
	input  logic              rst,
	input  logic              cyc,
	input  logic              stb,
	input  logic              we,
	input  mod_pkg::wb_adr_t  adr,
	input  mod_pkg::wb_data_t dat_w,
	output mod_pkg::wb_data_t dat_r,
	output logic              ack,
	lane_if.regs              lane_lo,
	lane_if.regs              lane_hi,
	input  mod_pkg::residue_t result,
	input  logic              result_strobe
);
	import mod_pkg::*;

	localparam int PAD_BITS = `WB_DATA_BITS - `RESIDUE_BITS - 2;

	wb_data_t operand [`OPERAND_WORDS];
	residue_t res_q;
	logic busy;
	logic valid;
	logic start;
	logic req;
	logic wr_operand;
	logic wr_start;

	// A request is taken only while ack is low, which keeps ack to a single cycle
	assign req = cyc && stb && !ack;

	// Operand and control writes are dropped while a reduction runs
	assign wr_operand = req && we && !busy && (adr < wb_adr_t'(`OPERAND_WORDS));
	assign wr_start = req && we && !busy && (adr == `ADR_CTRL) && dat_w[0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ack <= 1'b0;
			start <= 1'b0;
			busy <= 1'b0;
			valid <= 1'b0;
			res_q <= '0;
			for (int i = 0; i < `OPERAND_WORDS; i++)
				operand[i] <= '0;
		end
		else
		begin
			ack <= req;
			start <= wr_start;
			if (wr_operand)
				operand[adr] <= dat_w;
			if (wr_start)
				busy <= 1'b1;
			else if (result_strobe)
			begin
				busy <= 1'b0;
				valid <= 1'b1;
				res_q <= result;
			end
		end
	end

	// Read data is sampled with the request and presented during ack
	always_ff @(posedge clk)
	begin
		if (req)
		begin
			case (adr)
				`ADR_CTRL:
					dat_r <= '0;
				`ADR_STATUS:
					dat_r <= {busy, valid, PAD_BITS'(0), res_q};
				default:
					dat_r <= operand[adr];
			endcase
		end
	end

	assign lane_lo.start = start;
	assign lane_hi.start = start;

	// Word 0 is least significant
	assign lane_lo.operand = {operand[2], operand[1], operand[0]};
	assign lane_hi.operand = {operand[5], operand[4], operand[3]};

	// A result may only come back while a reduction is in progress
	assert property (@(posedge clk) disable iff (rst) result_strobe |-> busy)
		else $error("result strobe arrived while no reduction was running");

endmodule

// ==== src.f ====
+incdir+include
rtl/mod_pkg.sv
rtl/lane_if.sv
rtl/wb_mod_regs.sv
rtl/chunk_residue_lane.sv
rtl/residue_combiner.sv
rtl/mod2011_top.sv
test/tb_mod2011.sv

// ==== test/mod2011_testdata.txt ====
// Columns: operand word 5 down to word 0 (word 0 least significant),
// then the expected residue modulo 2011, all in hex
00000000 00000000 00000000 00000000 00000000 00000000 000
00000000 00000000 00000000 00000000 00000000 000007da 7da
00000000 00000000 00000000 00000000 00000000 000007db 000
00000000 00000000 00000000 00000000 00000000 000007dc 001
00000000 00000000 00000000 00000000 00000000 00000800 025
00000000 00000000 00000000 00000000 00000000 ffffffff 0bc
00000000 00000000 00000000 00000000 00000001 00000000 0bd
00000000 00000000 00000001 00000000 00000000 00000000 156
00000001 00000000 00000000 00000000 00000000 00000000 6e8
80000000 00000000 00000000 00000000 00000000 00000000 0a3
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff 145
00000000 00000000 00000000 ffffffff ffffffff ffffffff 155
ffffffff ffffffff ffffffff 00000000 00000000 00000000 7cb
00000000 00000000 00000000 00000000 00000000 12345678 502
00000000 00000000 00000000 00000000 00000000 deadbeef 549
00000001 00000001 00000001 00000001 00000001 00000001 062

// ==== test/tb_mod2011.sv ====
`timescale 1ns/1ps
`include "mod_params.svh"

module tb_mod2011;
	import mod_pkg::*;

	localparam int NUM_VECTORS = 16;
	localparam int VEC_COLUMNS = `OPERAND_WORDS + 1;
	localparam int NUM_RANDOM = 20;
	localparam int MAX_POLLS = 60;
	localparam int ACK_LIMIT = 8;
	// Each run gets 200 cycles, with six extra runs for reset and the directed tests
	localparam int WATCHDOG_CYCLES = (NUM_VECTORS + NUM_RANDOM + 6) * 200;

	logic clk;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	wb_adr_t adr;
	wb_data_t dat_w;
	wb_data_t dat_r;
	logic ack;

	wb_data_t vec_mem [NUM_VECTORS*VEC_COLUMNS];
	wb_data_t op_words [`OPERAND_WORDS];
	int error_count;
	int test_count;
	int test_fail_count;
	int test_errors_at_start;
	string test_name;

	mod2011_top mod2011_top_i (
		.clk   (clk),
		.rst   (rst),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.dat_r (dat_r),
		.ack   (ack)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			error_count++;
			$display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors_at_start = error_count;
	endtask

	task automatic end_test();
		int errors;
		errors = error_count - test_errors_at_start;
		test_count++;
		if (errors == 0)
			$display("pass  %s", test_name);
		else
		begin
			test_fail_count++;
			$display("fail  %s (%0d errors)", test_name, errors);
		end
	endtask

	// Ack is due in the cycle after the request, so it shows on the second edge
	task automatic wait_ack();
		int waits;
		waits = 0;
		@(posedge clk);
		while (!ack && waits < ACK_LIMIT)
		begin
			waits++;
			@(posedge clk);
		end
		check_value("ack delay", 32'(waits), 32'd1);
	endtask

	task automatic wb_write(input wb_adr_t a, input wb_data_t d);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b1;
		adr <= a;
		dat_w <= d;
		wait_ack();
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	// Read data is taken on the edge where ack is seen high
	task automatic wb_read(input wb_adr_t a, output wb_data_t d);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b0;
		adr <= a;
		wait_ack();
		d = dat_r;
		cyc <= 1'b0;
		stb <= 1'b0;
	endtask

	task automatic load_operand();
		for (int i = 0; i < `OPERAND_WORDS; i++)
			wb_write(wb_adr_t'(i), op_words[i]);
	endtask

	task automatic wait_idle(output wb_data_t status);
		int polls;
		polls = 0;
		wb_read(`ADR_STATUS, status);
		while (status[31] && polls < MAX_POLLS)
		begin
			polls++;
			wb_read(`ADR_STATUS, status);
		end
		if (status[31])
		begin
			error_count++;
			$display("Busy stayed set through %0d status reads in %s", MAX_POLLS, test_name);
		end
	endtask

	task automatic check_result(input wb_data_t status, input logic [31:0] expected);
		check_value("status.busy", 32'(status[31]), 32'd0);
		check_value("status.valid", 32'(status[30]), 32'd1);
		check_value("status.residue", 32'(status[`RESIDUE_BITS-1:0]), expected);
	endtask

	task automatic check_operand_readback();
		wb_data_t word;
		for (int i = 0; i < `OPERAND_WORDS; i++)
		begin
			wb_read(wb_adr_t'(i), word);
			check_value($sformatf("operand[%0d]", i), word, op_words[i]);
		end
	endtask

	task automatic run_and_check(input logic [31:0] expected);
		wb_data_t status;
		load_operand();
		wb_write(`ADR_CTRL, 32'd1);
		wait_idle(status);
		check_result(status, expected);
	endtask

	// Horner over 32-bit words, most significant first
	function automatic logic [31:0] expected_residue();
		logic [63:0] acc;
		acc = 64'd0;
		for (int i = `OPERAND_WORDS - 1; i >= 0; i--)
			acc = ((acc << 32) + 64'(op_words[i])) % 64'(`MOD_MODULUS);
		return acc[31:0];
	endfunction

	initial
	begin
		wb_data_t status;
		wb_data_t word;
		int fd;
		logic [31:0] expected;

		rst <= 1'b1;
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		adr <= '0;
		dat_w <= '0;
		error_count = 0;
		test_count = 0;
		test_fail_count = 0;
		void'($urandom(32'hf6790234));
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		begin_test("reset state");
		wb_read(`ADR_STATUS, status);
		check_value("status", status, 32'd0);
		for (int i = 0; i < `OPERAND_WORDS; i++)
		begin
			wb_read(wb_adr_t'(i), word);
			check_value($sformatf("operand[%0d]", i), word, 32'd0);
		end
		end_test();

		begin_test("operand readback");
		for (int i = 0; i < `OPERAND_WORDS; i++)
			op_words[i] = 32'hc3a5_0000 + 32'(i) * 32'h0001_1111;
		load_operand();
		check_operand_readback();
		wb_read(`ADR_CTRL, word);
		check_value("control", word, 32'd0);
		end_test();

		fd = $fopen("test/mod2011_testdata.txt", "r");
		if (fd == 0)
		begin
			begin_test("vector file");
			error_count++;
			$display("Could not open test/mod2011_testdata.txt for reading");
			end_test();
		end
		else
		begin
			$fclose(fd);
			$readmemh("test/mod2011_testdata.txt", vec_mem);
			for (int v = 0; v < NUM_VECTORS; v++)
			begin
				begin_test($sformatf("file vector %0d", v));
				// File columns run from word 5 down to word 0
				for (int i = 0; i < `OPERAND_WORDS; i++)
					op_words[i] = vec_mem[v*VEC_COLUMNS + `OPERAND_WORDS - 1 - i];
				run_and_check(vec_mem[v*VEC_COLUMNS + `OPERAND_WORDS]);
				end_test();
			end
		end

		for (int r = 0; r < NUM_RANDOM; r++)
		begin
			begin_test($sformatf("random operand %0d", r));
			for (int i = 0; i < `OPERAND_WORDS; i++)
				op_words[i] = $urandom();
			run_and_check(expected_residue());
			end_test();
		end

		begin_test("writes while busy");
		for (int i = 0; i < `OPERAND_WORDS; i++)
			op_words[i] = $urandom();
		expected = expected_residue();
		load_operand();
		wb_write(`ADR_CTRL, 32'd1);
		wb_read(`ADR_STATUS, status);
		check_value("status.busy", 32'(status[31]), 32'd1);
		wb_write(wb_adr_t'(0), ~op_words[0]);
		wb_write(wb_adr_t'(5), ~op_words[5]);
		wb_write(`ADR_CTRL, 32'd1);
		wait_idle(status);
		check_result(status, expected);
		check_operand_readback();
		end_test();

		begin_test("back-to-back runs");
		for (int i = 0; i < `OPERAND_WORDS; i++)
			op_words[i] = $urandom();
		run_and_check(expected_residue());
		for (int i = 0; i < `OPERAND_WORDS; i++)
			op_words[i] = $urandom();
		expected = expected_residue();
		load_operand();
		wb_write(`ADR_CTRL, 32'd1);
		wb_read(`ADR_STATUS, status);
		check_value("status.valid", 32'(status[30]), 32'd1);
		wait_idle(status);
		check_result(status, expected);
		end_test();

		$display("%0d tests, %0d passed, %0d failed, %0d errors", test_count,
			test_count - test_fail_count, test_fail_count, error_count);
		if (error_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
